/* Makefile */
# Verilator flow for the ECC protected APB memory
# make compile builds the simulator, make run runs it and checks sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 -f build.f --top-module tb_ecc_ram_apb -Mdir obj_dir

run: compile
	./obj_dir/Vtb_ecc_ram_apb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+logic
logic/ecc_code_pkg.sv
logic/apb_map_pkg.sv
logic/ram_req_if.sv
logic/ecc_word_decoder.sv
logic/ecc_status_stretch.sv
logic/ecc_protected_ram.sv
logic/apb_ram_port.sv
logic/ecc_ram_apb.sv
test/ecc_ram_checker.sv
test/tb_ecc_ram_apb.sv

/* logic/apb_map_pkg.sv */
// APB side of the design: byte address, region and the fault injection register
// flip positions index code_word_t, so values 52 to 63 flip nothing

`default_nettype none

package apb_map_pkg;

    typedef logic [11:0] paddr_t;       // APB byte address

    typedef enum logic [1:0] {
        REGION_MEM      = 2'd0,         // 0x000 to 0x0ff, word memory
        REGION_INJECT   = 2'd1,         // 0x100 to 0x103, injection register
        REGION_UNMAPPED = 2'd2          // everything else completes with pslverr
    } apb_region_e;

    typedef struct packed {
        logic       rsvd_hi;            // reads as zero
        logic       en_b;               // second flip enable
        logic [5:0] pos_b;              // second flip position
        logic       rsvd_lo;            // reads as zero
        logic       en_a;               // first flip enable
        logic [5:0] pos_a;              // first flip position
    } inject_reg_t;

endpackage

`default_nettype wire

/* logic/apb_ram_port.sv */
// APB slave with no wait states: every transfer is one setup and one access cycle
// memory requests go out in the setup cycle, read data returns in the access cycle
// the inject register honours pstrb for its two low bytes, reserved bits stay zero

`timescale 1ns/1ps
`default_nettype none

`include "ecc_ram_params.svh"

module apb_ram_port (
    input  wire                         clock,
    input  wire                         aclrn,
    input  wire                         i_psel,
    input  wire                         i_penable,
    input  wire                         i_pwrite,
    input  wire apb_map_pkg::paddr_t    i_paddr,
    input  wire ecc_code_pkg::word_t    i_pwdata,
    input  wire  [`RAM_LANES-1:0]       i_pstrb,
    output ecc_code_pkg::word_t         o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    ram_req_if.host                     req
);
    import ecc_code_pkg::*;
    import apb_map_pkg::*;

    logic        setup;         // first cycle of a transfer
    apb_region_e region;        // decode of the setup cycle address
    logic        mem_req;
    inject_reg_t inject_q;
    inject_reg_t inject_wr;     // register value after a write with strobes
    apb_region_e region_q;      // region of the transfer now in its access cycle
    logic        read_q;        // access cycle of a read

    assign setup = i_psel & ~i_penable;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    always_comb begin
        if (i_paddr < `ADDR_INJECT) begin
            region = REGION_MEM;
        end else if (i_paddr < `ADDR_LIMIT) begin
            region = REGION_INJECT;
        end else begin
            region = REGION_UNMAPPED;
        end
    end

    assign mem_req = setup & (region == REGION_MEM);

    // the memory captures the request on the edge that ends the setup cycle
    assign req.req_valid  = mem_req;
    assign req.req_write  = i_pwrite;
    assign req.req_addr   = i_paddr[$bits(addr_t)+1:2];    // byte offset to word address
    assign req.req_lanes  = i_pstrb;
    assign req.req_wdata  = i_pwdata;
    assign req.req_inject = inject_q;

    ////////////////////////////////////////
    // fault injection register
    ////////////////////////////////////////

    always_comb begin
        inject_wr = inject_q;
        if (i_pstrb[0]) begin
            inject_wr[7:0] = i_pwdata[7:0];
        end
        if (i_pstrb[1]) begin
            inject_wr[15:8] = i_pwdata[15:8];
        end
        inject_wr.rsvd_lo = 1'b0;
        inject_wr.rsvd_hi = 1'b0;
    end

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            inject_q  <= '0;
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
            read_q    <= 1'b0;
            region_q  <= REGION_UNMAPPED;
        end else begin
            o_pready  <= setup;                                 // no wait states
            o_pslverr <= setup & (region == REGION_UNMAPPED);
            read_q    <= setup & ~i_pwrite;
            if (setup) begin
                region_q <= region;
            end
            // any memory write uses up the injection, even with no lane enabled
            if (mem_req && i_pwrite) begin
                inject_q <= '0;
            end else if (setup && i_pwrite && region == REGION_INJECT) begin
                inject_q <= inject_wr;
            end
        end
    end

    // read data only drives during the access cycle of a read
    always_comb begin
        o_prdata = '0;
        if (read_q) begin
            case (region_q)
                REGION_MEM:    o_prdata = req.rsp_data;
                REGION_INJECT: o_prdata = word_t'(inject_q);
                default:       o_prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/ecc_code_pkg.sv */
// data and codeword types plus the SECDED code for one byte lane
// codeword bit 0 is overall parity, bits 1 to 12 are hamming positions 1 to 12
// the encoder places data in the non power of two positions in ascending order

`default_nettype none

`include "ecc_ram_params.svh"

package ecc_code_pkg;

    typedef logic [`RAM_LANES*`LANE_BITS-1:0] word_t;       // one data word
    typedef logic [`LANE_BITS-1:0]            lane_data_t;  // data bits of one lane
    typedef logic [`CODE_BITS-1:0]            lane_code_t;  // codeword of one lane
    typedef logic [`RAM_LANES*`CODE_BITS-1:0] code_word_t;  // lane n sits at bits 13n+12:13n
    typedef logic [$clog2(`RAM_DEPTH)-1:0]    addr_t;       // word address
    typedef logic [$clog2(`CODE_BITS)-1:0]    syndrome_t;   // hamming position of a single flip

    // builds the 13-bit codeword, every parity bit covers the positions with its bit set
    function automatic lane_code_t secded_encode(lane_data_t data);
        lane_code_t code;
        int         k;
        code = '0;
        k    = 0;
        for (int pos = 1; pos < `CODE_BITS; pos++) begin
            if ((pos & (pos - 1)) != 0) begin   // not a power of two, so a data position
                code[pos] = data[k];
                k++;
            end
        end
        for (int p = 1; p < `CODE_BITS; p = p * 2) begin
            for (int pos = p + 1; pos < `CODE_BITS; pos++) begin
                if ((pos & p) != 0) begin
                    code[p] = code[p] ^ code[pos];
                end
            end
        end
        code[0] = ^code[`CODE_BITS-1:1];        // even parity over the whole codeword
        return code;
    endfunction

    // zero for a clean hamming part, otherwise the position of a single flipped bit
    function automatic syndrome_t secded_syndrome(lane_code_t code);
        syndrome_t syn;
        syn = '0;
        for (int pos = 1; pos < `CODE_BITS; pos++) begin
            for (int b = 0; b < $bits(syndrome_t); b++) begin
                if (((pos >> b) & 1) != 0) begin
                    syn[b] = syn[b] ^ code[pos];
                end
            end
        end
        return syn;
    endfunction

endpackage

`default_nettype wire

/* logic/ecc_protected_ram.sv */
// word memory of 13-bit SECDED codewords, one per byte lane
// a write encodes, applies the injected flips and stores only enabled lanes
// a read registers the codeword, decode happens in the following cycle

`timescale 1ns/1ps
`default_nettype none

`include "ecc_ram_params.svh"

module ecc_protected_ram (
    input  wire     clock,
    input  wire     aclrn,
    ram_req_if.mem  req,
    output logic    o_any_single,
    output logic    o_any_double
);
    import ecc_code_pkg::*;

    code_word_t            storage [`RAM_DEPTH];
    code_word_t            flip_mask;       // injected flips, zero when nothing is armed
    code_word_t            wr_code;         // encoded write word with flips applied
    code_word_t            rd_code_q;
    logic                  rd_valid_q;      // rd_code_q belongs to a read this cycle
    logic [`RAM_LANES-1:0] lane_single;
    logic [`RAM_LANES-1:0] lane_double;

    always_comb begin
        flip_mask = '0;
        if (req.req_inject.en_a) begin
            flip_mask = flip_mask | (code_word_t'(1) << req.req_inject.pos_a);
        end
        if (req.req_inject.en_b) begin
            flip_mask = flip_mask | (code_word_t'(1) << req.req_inject.pos_b);
        end
        for (int n = 0; n < `RAM_LANES; n++) begin
            wr_code[n*`CODE_BITS +: `CODE_BITS] =
                secded_encode(req.req_wdata[n*`LANE_BITS +: `LANE_BITS]) ^
                flip_mask[n*`CODE_BITS +: `CODE_BITS];
        end
    end

    // lanes without an enable keep their old codeword, a flip aimed at them is dropped
    always_ff @(posedge clock) begin
        if (req.req_valid && req.req_write) begin
            for (int n = 0; n < `RAM_LANES; n++) begin
                if (req.req_lanes[n]) begin
                    storage[req.req_addr][n*`CODE_BITS +: `CODE_BITS] <=
                        wr_code[n*`CODE_BITS +: `CODE_BITS];
                end
            end
        end
        if (req.req_valid && !req.req_write) begin
            rd_code_q <= storage[req.req_addr];
        end
    end

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= req.req_valid & ~req.req_write;
        end
    end

    ecc_word_decoder ecc_word_decoder_inst (
        .i_code        (rd_code_q),
        .o_data        (req.rsp_data),
        .o_lane_single (lane_single),
        .o_lane_double (lane_double)
    );

    // stale codewords outside a read cycle must not raise status
    assign req.rsp_single = rd_valid_q & (|lane_single);
    assign req.rsp_double = rd_valid_q & (|lane_double);
    assign o_any_single   = req.rsp_single;
    assign o_any_double   = req.rsp_double;

endmodule

`default_nettype wire

/* logic/ecc_ram_apb.sv */
// ECC protected 64 x 32 memory behind an APB slave
// transfers always take two cycles, pready rises in the access cycle
// o_ecc_status bit 1 is stretched single error, bit 0 is sticky double error

`timescale 1ns/1ps
`default_nettype none

`include "ecc_ram_params.svh"

module ecc_ram_apb (
    input  wire                         clock,
    input  wire                         aclrn,
    input  wire                         i_psel,
    input  wire                         i_penable,
    input  wire                         i_pwrite,
    input  wire apb_map_pkg::paddr_t    i_paddr,
    input  wire ecc_code_pkg::word_t    i_pwdata,
    input  wire  [`RAM_LANES-1:0]       i_pstrb,
    output ecc_code_pkg::word_t         o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output logic [1:0]                  o_ecc_status
);

    logic any_single;       // a read corrected a lane this cycle
    logic any_double;       // a read found an uncorrectable lane this cycle

    ram_req_if req_if ();

    apb_ram_port apb_ram_port_inst (
        .clock      (clock),
        .aclrn      (aclrn),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .i_pstrb    (i_pstrb),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .req        (req_if.host)
    );

    ecc_protected_ram ecc_protected_ram_inst (
        .clock        (clock),
        .aclrn        (aclrn),
        .req          (req_if.mem),
        .o_any_single (any_single),
        .o_any_double (any_double)
    );

    ecc_status_stretch #(
        .STRETCH (`STATUS_STRETCH)
    ) ecc_status_stretch_inst (
        .clock    (clock),
        .aclrn    (aclrn),
        .i_single (any_single),
        .i_double (any_double),
        .o_status (o_ecc_status)
    );

endmodule

`default_nettype wire

/* logic/ecc_ram_params.svh */
// sizing and address map shared by the RTL and the testbench
// lane geometry is fixed at 8 data bits in a 13-bit SECDED codeword
// changing LANE_BITS alone does not re-derive CODE_BITS

`ifndef ECC_RAM_PARAMS_SVH
`define ECC_RAM_PARAMS_SVH

`define RAM_DEPTH       64          // words in the memory
`define RAM_LANES       4           // byte lanes per word, one pstrb bit each
`define LANE_BITS       8           // data bits per lane
`define CODE_BITS       13          // coded bits per lane: 8 data, 4 hamming, 1 overall parity

`define STATUS_STRETCH  3           // extra cycles the single error status bit is held

`define ADDR_INJECT     12'h100     // byte offset of the fault injection register
`define ADDR_LIMIT      12'h104     // first address that is not mapped

`endif

/* logic/ecc_status_stretch.sv */
// status bit 1 is the single error flag held for 1 + STRETCH cycles after the last flag
// status bit 0 is the double error flag, sticky until aclrn
// STRETCH must be at least 1

`timescale 1ns/1ps
`default_nettype none

`include "ecc_ram_params.svh"

module ecc_status_stretch #(
    parameter int STRETCH = `STATUS_STRETCH
) (
    input  wire        clock,
    input  wire        aclrn,
    input  wire        i_single,
    input  wire        i_double,
    output logic [1:0] o_status
);

    logic [STRETCH-1:0] single_hist;    // single flags of the last STRETCH cycles
    logic               single_held;
    logic               double_held;

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            single_hist <= '0;
            single_held <= 1'b0;
            double_held <= 1'b0;
        end else begin
            single_hist[0] <= i_single;
            for (int i = 1; i < STRETCH; i++) begin
                single_hist[i] <= single_hist[i-1];
            end
            single_held <= i_single | (|single_hist);   // high while any recent flag remains
            double_held <= double_held | i_double;      // only reset clears this
        end
    end

    assign o_status = {single_held, double_held};

endmodule

`default_nettype wire

/* logic/ecc_word_decoder.sv */
// combinational SECDED decode of one word, each byte lane on its own
// odd overall parity means one flip, corrected when it lands in positions 1 to 12
// even parity with a nonzero syndrome is a double error, data passes uncorrected

`timescale 1ns/1ps
`default_nettype none

`include "ecc_ram_params.svh"

module ecc_word_decoder (
    input  wire ecc_code_pkg::code_word_t i_code,
    output ecc_code_pkg::word_t           o_data,
    output logic [`RAM_LANES-1:0]         o_lane_single,
    output logic [`RAM_LANES-1:0]         o_lane_double
);
    import ecc_code_pkg::*;

    for (genvar n = 0; n < `RAM_LANES; n++) begin : g_lane
        lane_code_t code;
        lane_code_t fixed;      // codeword after the single bit repair
        syndrome_t  syn;
        logic       odd;        // overall parity fails

        assign code = i_code[n*`CODE_BITS +: `CODE_BITS];
        assign syn  = secded_syndrome(code);
        assign odd  = ^code;

        // zero syndrome with odd parity points at bit 0, the overall parity bit itself
        // syndromes past position 12 shift out of the codeword and repair nothing
        assign fixed = odd ? (code ^ (lane_code_t'(1) << syn)) : code;

        // data positions 3, 5, 6, 7, 9, 10, 11 and 12 carry data bits 0 to 7
        assign o_data[n*`LANE_BITS +: `LANE_BITS] = {fixed[12], fixed[11], fixed[10], fixed[9],
                                                     fixed[7], fixed[6], fixed[5], fixed[3]};

        assign o_lane_single[n] = odd;
        assign o_lane_double[n] = ~odd & (syn != '0);
    end

endmodule

`default_nettype wire

/* logic/ram_req_if.sv */
// one memory request and its decoded response
// the request is a single cycle strobe, the memory accepts every cycle
// the response is valid in the cycle after a read strobe

`timescale 1ns/1ps
`default_nettype none

`include "ecc_ram_params.svh"

interface ram_req_if;
    import ecc_code_pkg::*;
    import apb_map_pkg::*;

    logic                  req_valid;   // request strobe
    logic                  req_write;   // 1 write, 0 read
    addr_t                 req_addr;
    logic [`RAM_LANES-1:0] req_lanes;   // byte enables of a write
    word_t                 req_wdata;
    inject_reg_t           req_inject;  // flips applied to the next write
    word_t                 rsp_data;    // corrected read data
    logic                  rsp_single;  // a lane was corrected
    logic                  rsp_double;  // a lane holds an uncorrectable error

    modport host (output req_valid, req_write, req_addr, req_lanes, req_wdata, req_inject,
                  input  rsp_data, rsp_single, rsp_double);

    modport mem  (input  req_valid, req_write, req_addr, req_lanes, req_wdata, req_inject,
                  output rsp_data, rsp_single, rsp_double);

endinterface

`default_nettype wire

/* test/ecc_ram_checker.sv */
// compares the DUT's APB responses with the expected values posted by the driver
// each transfer is checked on the rising edge inside its access cycle
// status is compared as it stands in that cycle, before the transfer's own effect

`timescale 1ns/1ps
`default_nettype none

module ecc_ram_checker (
    input  wire                         clock,
    input  wire                         aclrn,
    input  wire                         i_psel,
    input  wire                         i_penable,
    input  wire apb_map_pkg::paddr_t    i_paddr,
    input  wire ecc_code_pkg::word_t    i_prdata,
    input  wire                         i_pready,
    input  wire                         i_pslverr,
    input  wire [1:0]                   i_ecc_status,
    input  wire ecc_code_pkg::word_t    i_exp_data,
    input  wire [1:0]                   i_exp_status,
    input  wire [2:0]                   i_exp_flags,    // data, status, expected pslverr
    output int                          o_checks,
    output int                          o_errors
);

    always @(posedge clock or negedge aclrn) begin : compare
        int errs;
        if (!aclrn) begin
            o_checks <= 0;
            o_errors <= 0;
        end else if (i_psel && i_penable) begin    // access cycle
            errs = 0;
            if (i_pready !== 1'b1) begin
                $display("%0t: transfer at %h did not complete in its second cycle",
                         $time, i_paddr);
                errs++;
            end
            if (i_pslverr !== i_exp_flags[2]) begin
                $display("%0t: pslverr was %b but %b was expected at address %h",
                         $time, i_pslverr, i_exp_flags[2], i_paddr);
                errs++;
            end
            // read data only where the record asks for it, double error reads are skipped
            if (i_exp_flags[0] && i_prdata !== i_exp_data) begin
                $display("CHECK FAILED o_prdata got %h expected %h at address %h",
                         i_prdata, i_exp_data, i_paddr);
                errs++;
            end
            if (i_exp_flags[1] && i_ecc_status !== i_exp_status) begin
                $display("CHECK FAILED o_ecc_status got %h expected %h at address %h",
                         i_ecc_status, i_exp_status, i_paddr);
                errs++;
            end
            o_checks <= o_checks + 1;
            o_errors <= o_errors + errs;
        end
    end

endmodule

`default_nettype wire

/* test/ecc_ram_vectors.hex */
// test_op_addr_data_strb_expect_status_flags, op 1 write 2 read 3 wait data cycles f end
// flags bit 0 check data, bit 1 check status, bit 2 pslverr expected
2_1_010_11223344_f_00000000_0_0
2_2_010_00000000_0_11223344_0_3
2_1_010_aabbccdd_5_00000000_0_0
2_2_010_00000000_0_11bb33dd_0_3
2_1_010_55667788_a_00000000_0_0
2_2_010_00000000_0_55bb77dd_0_3
3_1_100_00000047_3_00000000_0_0
3_1_020_cafef00d_f_00000000_0_0
3_2_020_00000000_0_cafef00d_0_3
3_2_020_00000000_0_cafef00d_2_3
3_3_000_00000005_0_00000000_0_0
3_2_100_00000000_0_00000000_0_3
3_1_100_00007340_3_00000000_0_0
3_1_024_01234567_f_00000000_0_0
3_2_024_00000000_0_01234567_0_3
3_2_024_00000000_0_01234567_2_3
4_1_100_00004543_3_00000000_0_0
4_1_030_deadbeef_f_00000000_0_0
4_2_030_00000000_0_00000000_0_0
4_2_010_00000000_0_55bb77dd_1_3
4_1_100_00004f4e_3_00000000_0_0
4_1_010_000000a5_1_00000000_0_0
4_2_010_00000000_0_55bb77a5_1_3
4_2_010_00000000_0_55bb77a5_1_3
5_1_100_00006154_3_00000000_0_0
5_2_100_00000000_0_00006154_1_3
5_1_03c_12345678_f_00000000_0_0
5_2_100_00000000_0_00000000_1_3
5_1_104_00000000_f_00000000_0_4
5_2_200_00000000_0_00000000_0_5
5_2_ffc_00000000_0_00000000_0_4
0_f_000_00000000_0_00000000_0_0

/* test/tb_ecc_ram_apb.sv */
// testbench for the ECC protected APB memory, run from the project root
// directed records come from test/ecc_ram_vectors.hex, one 96-bit record per line
// APB inputs change on falling edges and the checker samples on rising edges

`timescale 1ns/1ps
`default_nettype none

`include "ecc_ram_params.svh"

module tb_ecc_ram_apb;
    import ecc_code_pkg::*;
    import apb_map_pkg::*;

    localparam int MAX_RECS        = 64;                // room in the record array
    localparam int SWEEP_TRANSFERS = 2 * `RAM_DEPTH;    // one write and one read per word

    logic                  clock;
    logic                  aclrn;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    paddr_t                paddr;
    word_t                 pwdata;
    logic [`RAM_LANES-1:0] pstrb;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    logic [1:0]            ecc_status;

    word_t                 exp_data;        // posted to the checker before each access cycle
    logic [1:0]            exp_status;
    logic [2:0]            exp_flags;       // bit 0 data, bit 1 status, bit 2 expected pslverr
    int                    check_count;
    int                    error_count;
    int                    bad_records = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 0; // stays zero until the records are counted
    logic [31:0]           lcg_state   = 32'hb8;
    logic [95:0]           vectors [MAX_RECS];

    ecc_ram_apb ecc_ram_apb_inst (
        .clock        (clock),
        .aclrn        (aclrn),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .i_pstrb      (pstrb),
        .o_prdata     (prdata),
        .o_pready     (pready),
        .o_pslverr    (pslverr),
        .o_ecc_status (ecc_status)
    );

    ecc_ram_checker ecc_ram_checker_inst (
        .clock        (clock),
        .aclrn        (aclrn),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_paddr      (paddr),
        .i_prdata     (prdata),
        .i_pready     (pready),
        .i_pslverr    (pslverr),
        .i_ecc_status (ecc_status),
        .i_exp_data   (exp_data),
        .i_exp_status (exp_status),
        .i_exp_flags  (exp_flags),
        .o_checks     (check_count),
        .o_errors     (error_count)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;      // 4 ns period
    end

    // the limit is set once the vectors are counted, a stuck transfer lands here
    initial begin
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic string test_name(int id);
        case (id)
            1:       return "lcg sweep";
            2:       return "byte lanes";
            3:       return "single error correction";
            4:       return "double error detection";
            5:       return "address map";
            default: return "unnamed";
        endcase
    endfunction

    // one setup and one access cycle, entered and left on a falling edge
    task automatic apb_transfer(input logic is_write, input paddr_t addr, input word_t data,
                                input logic [`RAM_LANES-1:0] strb, input word_t want_data,
                                input logic [1:0] want_status, input logic [2:0] flags);
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = is_write;
        paddr      = addr;
        pwdata     = data;
        pstrb      = strb;
        exp_data   = want_data;     // the checker compares at the access cycle edge
        exp_status = want_status;
        exp_flags  = flags;
        @(negedge clock);
        penable = 1'b1;
        @(posedge clock);
        while (!pready) begin       // a late pready is also flagged by the checker
            @(posedge clock);
        end
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic report_test(int id, int errors_before);
        int errors;
        errors = error_count - errors_before;
        if (errors == 0) begin
            $display("test %0d %s: ok", id, test_name(id));
        end else begin
            $display("test %0d %s: %0d errors", id, test_name(id), errors);
        end
    endtask

    // fills every word with LCG data, then reads it all back with status expected clean
    task automatic run_sweep();
        word_t model [`RAM_DEPTH];
        int    errors_before;
        errors_before = error_count;
        for (int a = 0; a < `RAM_DEPTH; a++) begin
            model[a] = lcg_next();
            apb_transfer(1'b1, paddr_t'(a * 4), model[a], 4'hf, '0, 2'b00, 3'b010);
        end
        for (int a = 0; a < `RAM_DEPTH; a++) begin
            apb_transfer(1'b0, paddr_t'(a * 4), '0, 4'h0, model[a], 2'b00, 3'b011);
        end
        report_test(1, errors_before);
    endtask

    // record fields, msb first: test, op, addr, data, strb, expect, status, flags
    task automatic run_vectors(int n_recs);
        logic [95:0] rec;
        int          cur_test;
        int          errors_before;
        cur_test      = 0;
        errors_before = error_count;
        for (int i = 0; i < n_recs; i++) begin
            rec = vectors[i];
            if (int'(rec[95:92]) != cur_test) begin   // a new test number closes the last one
                if (cur_test != 0) begin
                    report_test(cur_test, errors_before);
                end
                cur_test      = int'(rec[95:92]);
                errors_before = error_count;
            end
            case (rec[91:88])
                4'h1, 4'h2: apb_transfer(rec[91:88] == 4'h1, rec[87:76], rec[75:44],
                                         rec[43:40], rec[39:8], rec[5:4], rec[2:0]);
                4'h3:       repeat (rec[75:44]) @(negedge clock);   // idle, psel low
                default: begin
                    $display("record %0d has an unknown operation %h", i, rec[91:88]);
                    bad_records++;
                end
            endcase
        end
        if (cur_test != 0) begin
            report_test(cur_test, errors_before);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int n_recs;
        int transfers;
        int waits;
        aclrn      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pstrb      = '0;
        exp_data   = '0;
        exp_status = 2'b00;
        exp_flags  = 3'b000;
        $readmemh("test/ecc_ram_vectors.hex", vectors);
        n_recs    = 0;
        transfers = 0;
        waits     = 0;
        while (n_recs < MAX_RECS && vectors[n_recs][91:88] !== 4'hf) begin
            if (vectors[n_recs][91:88] == 4'h3) begin
                waits += int'(vectors[n_recs][75:44]);
            end else begin
                transfers++;
            end
            n_recs++;
        end
        cycle_limit = 2 * (transfers + SWEEP_TRANSFERS) + waits + 100;
        repeat (5) @(negedge clock);    // reset held for 5 cycles
        aclrn = 1'b1;
        if (n_recs == MAX_RECS) begin
            $display("the vectors file is missing or has no end record");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            run_sweep();
            run_vectors(n_recs);
            $display("summary: %0d checks, %0d errors, %0d bad records",
                     check_count, error_count, bad_records);
            if (error_count == 0 && bad_records == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
